// File: logic/arenaPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Arena geometry, coordinate widths, start positions,
// plot colours and the clearing sweep length
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package arenaPkg;

    // Coordinates address a 160 by 120 pixel grid
    localparam int xWidth = 8;
    localparam int yWidth = 7;

    // Border lines that end a round when a rider lands on them
    localparam logic [xWidth-1:0] xWallLeft   = 8'd10;
    localparam logic [xWidth-1:0] xWallRight  = 8'd149;
    localparam logic [yWidth-1:0] yWallTop    = 7'd17;
    localparam logic [yWidth-1:0] yWallBottom = 7'd108;

    // Interior of the field, the area covered by the clearing sweep
    localparam logic [xWidth-1:0] xFirst = 8'd11;
    localparam logic [xWidth-1:0] xLast  = 8'd148;
    localparam logic [yWidth-1:0] yFirst = 7'd18;
    localparam logic [yWidth-1:0] yLast  = 7'd107;

    // Default start positions, both riders begin on the same row
    localparam logic [xWidth-1:0] startX1 = 8'd25;
    localparam logic [xWidth-1:0] startX2 = 8'd135;
    localparam logic [yWidth-1:0] startY  = 7'd100;

    // Three bit RGB plot colours
    localparam int colourWidth = 3;
    localparam logic [colourWidth-1:0] colourRider1 = 3'b001;
    localparam logic [colourWidth-1:0] colourRider2 = 3'b100;
    localparam logic [colourWidth-1:0] colourClear  = 3'b000;

    // 138 columns times 90 rows of interior pixels
    localparam int sweepWidth = 14;
    localparam logic [sweepWidth-1:0] sweepLength = 14'd12420;

endpackage

// File: logic/steerPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Rider heading encoding and steering key layout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package steerPkg;

    // Direction of travel, down is the heading after reset and after a round
    typedef enum logic [1:0] {
        headDown  = 2'd0,
        headRight = 2'd1,
        headUp    = 2'd2,
        headLeft  = 2'd3
    } heading_t;

    // Each rider has one key per direction
    localparam int steerWidth = 4;

    // Bit positions inside the key field, same order as the board switches
    localparam int keyRight = 0;
    localparam int keyUp    = 1;
    localparam int keyDown  = 2;
    localparam int keyLeft  = 3;

endpackage

// File: logic/moveTimer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Movement tick generator with slow and fast period
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module moveTimer #(
    parameter int slowPeriod = 12,
    parameter int fastPeriod = 6
) (
    input  logic clk,
    input  logic resetn,
    input  logic fast,
    output logic tick
);

    // The counter must hold the longer of the two reload values
    localparam int periodMax  = (slowPeriod > fastPeriod) ? slowPeriod : fastPeriod;
    localparam int countWidth = $clog2(periodMax + 1);
    localparam logic [countWidth-1:0] slowLoad = countWidth'(slowPeriod - 1);
    localparam logic [countWidth-1:0] fastLoad = countWidth'(fastPeriod - 1);

    logic [countWidth-1:0] count;
    logic [countWidth-1:0] reload;
    logic                  lastFast;
    logic                  speedChange;

    assign reload      = fast ? fastLoad : slowLoad;
    assign speedChange = fast != lastFast;

    // A speed change swallows a pending expiry so the new period starts clean
    assign tick = (count == '0) && !speedChange;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            count    <= reload;
            lastFast <= fast;
        end else begin
            lastFast <= fast;
            // Reload on expiry, and also whenever the speed select moved
            if (speedChange || count == '0) begin
                count <= reload;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: logic/riderSteer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Heading FSM of one rider, perpendicular turns only
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module riderSteer (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic                            hold,
    input  logic [steerPkg::steerWidth-1:0] keys,
    output steerPkg::heading_t              heading
);

    steerPkg::heading_t nextHeading;
    logic               singleKey;
    logic               vertical;

    // Several keys at once are treated as no steering at all
    assign singleKey = $onehot(keys);

    // Riders moving up or down may only turn left or right, and the reverse
    assign vertical = (heading == steerPkg::headDown) || (heading == steerPkg::headUp);

    always_comb begin
        nextHeading = heading;
        if (singleKey) begin
            if (vertical) begin
                if (keys[steerPkg::keyRight]) begin
                    nextHeading = steerPkg::headRight;
                end else if (keys[steerPkg::keyLeft]) begin
                    nextHeading = steerPkg::headLeft;
                end
            end else begin
                if (keys[steerPkg::keyUp]) begin
                    nextHeading = steerPkg::headUp;
                end else if (keys[steerPkg::keyDown]) begin
                    nextHeading = steerPkg::headDown;
                end
            end
        end
        // A reversal key falls through both branches and keeps the heading
    end

    // The heading follows the keys every clock, not only on movement ticks
    always_ff @(posedge clk) begin
        if (!resetn || hold) begin
            heading <= steerPkg::headDown;
        end else begin
            heading <= nextHeading;
        end
    end

endmodule

// File: logic/rider.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One rider, heading FSM and position registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module rider #(
    parameter logic [arenaPkg::xWidth-1:0] startX = arenaPkg::startX1,
    parameter logic [arenaPkg::yWidth-1:0] startY = arenaPkg::startY
) (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic                            tick,
    input  logic                            hold,
    input  logic [steerPkg::steerWidth-1:0] keys,
    output logic [arenaPkg::xWidth-1:0]     posX,
    output logic [arenaPkg::yWidth-1:0]     posY
);

    steerPkg::heading_t heading;

    riderSteer steer (
        .clk     (clk),
        .resetn  (resetn),
        .hold    (hold),
        .keys    (keys),
        .heading (heading)
    );

    // Screen rows grow downwards, so moving up decrements y
    always_ff @(posedge clk) begin
        if (!resetn || hold) begin
            posX <= startX;
            posY <= startY;
        end else if (tick) begin
            case (heading)
                steerPkg::headDown: begin
                    posY <= posY + 1'b1;
                end
                steerPkg::headUp: begin
                    posY <= posY - 1'b1;
                end
                steerPkg::headRight: begin
                    posX <= posX + 1'b1;
                end
                steerPkg::headLeft: begin
                    posX <= posX - 1'b1;
                end
                default: begin
                    posX <= posX;
                end
            endcase
        end
    end

endmodule

// File: logic/arenaReferee.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Crash tests, plot sequencing, clearing sweep and
// point pulses for both riders
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module arenaReferee (
    input  logic                             clk,
    input  logic                             resetn,
    input  logic                             tick,
    input  logic [arenaPkg::xWidth-1:0]      pos1X,
    input  logic [arenaPkg::yWidth-1:0]      pos1Y,
    input  logic [arenaPkg::xWidth-1:0]      pos2X,
    input  logic [arenaPkg::yWidth-1:0]      pos2Y,
    output logic [arenaPkg::xWidth-1:0]      plotX,
    output logic [arenaPkg::yWidth-1:0]      plotY,
    output logic [arenaPkg::colourWidth-1:0] plotColour,
    output logic                             plotEn,
    output logic                             roundOver,
    output logic                             point1,
    output logic                             point2
);

    // Phases of one movement tick, judge is the cycle after the tick
    localparam logic [1:0] phaseIdle  = 2'd0;
    localparam logic [1:0] phaseJudge = 2'd1;
    localparam logic [1:0] phasePlot2 = 2'd2;

    logic [1:0]                        phase;
    logic                              crash1;
    logic                              crash2;
    logic                              headOn;
    logic                              anyCrash;
    logic                              sweepStep;
    logic [arenaPkg::sweepWidth-1:0]   sweepLeft;
    logic [arenaPkg::xWidth-1:0]       sweepX;
    logic [arenaPkg::yWidth-1:0]       sweepY;

    // True when a position lies on any of the four border lines
    function automatic logic onWall(
        input logic [arenaPkg::xWidth-1:0] x,
        input logic [arenaPkg::yWidth-1:0] y
    );
        return (x == arenaPkg::xWallLeft) || (x == arenaPkg::xWallRight) ||
               (y == arenaPkg::yWallTop) || (y == arenaPkg::yWallBottom);
    endfunction

    // Both riders get the same tests, a head-on meeting takes both out
    assign headOn   = (pos1X == pos2X) && (pos1Y == pos2Y);
    assign crash1   = onWall(pos1X, pos1Y) || headOn;
    assign crash2   = onWall(pos2X, pos2Y) || headOn;
    assign anyCrash = crash1 || crash2;

    // The sweep runs while pixels remain, one per cycle
    assign sweepStep = roundOver && (sweepLeft != '0);

    // Control state, phases, strobes and the round-over level
    always_ff @(posedge clk) begin
        if (!resetn) begin
            phase     <= phaseIdle;
            plotEn    <= 1'b0;
            roundOver <= 1'b0;
            point1    <= 1'b0;
            point2    <= 1'b0;
            sweepLeft <= '0;
        end else begin
            plotEn <= 1'b0;
            point1 <= 1'b0;
            point2 <= 1'b0;
            if (roundOver) begin
                // Ticks are ignored until the field is black again
                phase <= phaseIdle;
                if (sweepStep) begin
                    plotEn    <= 1'b1;
                    sweepLeft <= sweepLeft - 1'b1;
                end else begin
                    roundOver <= 1'b0;
                end
            end else begin
                case (phase)
                    phaseIdle: begin
                        if (tick) begin
                            phase <= phaseJudge;
                        end
                    end
                    phaseJudge: begin
                        if (anyCrash) begin
                            // Only a lone crash hands the other rider a point
                            roundOver <= 1'b1;
                            sweepLeft <= arenaPkg::sweepLength;
                            point1    <= crash2 && !crash1;
                            point2    <= crash1 && !crash2;
                            phase     <= phaseIdle;
                        end else begin
                            plotEn <= 1'b1;
                            phase  <= phasePlot2;
                        end
                    end
                    phasePlot2: begin
                        plotEn <= 1'b1;
                        phase  <= phaseIdle;
                    end
                    default: begin
                        phase <= phaseIdle;
                    end
                endcase
            end
        end
    end

    // Plot payload and sweep position, only meaningful alongside plotEn
    always_ff @(posedge clk) begin
        if (roundOver) begin
            if (sweepStep) begin
                plotX      <= sweepX;
                plotY      <= sweepY;
                plotColour <= arenaPkg::colourClear;
                // Rows run inside each column, then move one column right
                if (sweepY == arenaPkg::yLast) begin
                    sweepY <= arenaPkg::yFirst;
                    sweepX <= sweepX + 1'b1;
                end else begin
                    sweepY <= sweepY + 1'b1;
                end
            end
        end else if (phase == phaseJudge) begin
            if (anyCrash) begin
                sweepX <= arenaPkg::xFirst;
                sweepY <= arenaPkg::yFirst;
            end else begin
                plotX      <= pos1X;
                plotY      <= pos1Y;
                plotColour <= arenaPkg::colourRider1;
            end
        end else if (phase == phasePlot2) begin
            // Rider 2 has not moved since the judge cycle
            plotX      <= pos2X;
            plotY      <= pos2Y;
            plotColour <= arenaPkg::colourRider2;
        end
    end

endmodule

// File: logic/scoreBoard.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two digit BCD score counters for both riders
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module scoreBoard (
    input  logic       clk,
    input  logic       resetn,
    input  logic       point1,
    input  logic       point2,
    output logic [7:0] score1,
    output logic [7:0] score2
);

    // Tens in the upper nibble, ones in the lower, 99 wraps to 00
    function automatic logic [7:0] bcdStep(input logic [7:0] score);
        logic [3:0] tens;
        logic [3:0] ones;
        tens = score[7:4];
        ones = score[3:0];
        if (ones == 4'd9) begin
            ones = 4'd0;
            tens = (tens == 4'd9) ? 4'd0 : tens + 1'b1;
        end else begin
            ones = ones + 1'b1;
        end
        return {tens, ones};
    endfunction

    always_ff @(posedge clk) begin
        if (!resetn) begin
            score1 <= 8'h00;
            score2 <= 8'h00;
        end else begin
            if (point1) begin
                score1 <= bcdStep(score1);
            end
            if (point2) begin
                score2 <= bcdStep(score2);
            end
        end
    end

endmodule

// File: logic/tronArena.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Light-cycle arena top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tronArena #(
    parameter int                          slowPeriod = 12,
    parameter int                          fastPeriod = 6,
    parameter logic [arenaPkg::xWidth-1:0] startX1    = arenaPkg::startX1,
    parameter logic [arenaPkg::xWidth-1:0] startX2    = arenaPkg::startX2,
    parameter logic [arenaPkg::yWidth-1:0] startY     = arenaPkg::startY
) (
    input  logic                             clk,
    input  logic                             resetn,
    input  logic                             fast,
    input  logic [steerPkg::steerWidth-1:0]  steer1,
    input  logic [steerPkg::steerWidth-1:0]  steer2,
    output logic [arenaPkg::xWidth-1:0]      plotX,
    output logic [arenaPkg::yWidth-1:0]      plotY,
    output logic [arenaPkg::colourWidth-1:0] plotColour,
    output logic                             plotEn,
    output logic                             roundOver,
    output logic [7:0]                       score1,
    output logic [7:0]                       score2
);

    logic                        tick;
    logic [arenaPkg::xWidth-1:0] pos1X;
    logic [arenaPkg::yWidth-1:0] pos1Y;
    logic [arenaPkg::xWidth-1:0] pos2X;
    logic [arenaPkg::yWidth-1:0] pos2Y;
    logic                        point1;
    logic                        point2;

    // One movement tick drives both riders and starts the referee
    moveTimer #(
        .slowPeriod (slowPeriod),
        .fastPeriod (fastPeriod)
    ) timer (
        .clk    (clk),
        .resetn (resetn),
        .fast   (fast),
        .tick   (tick)
    );

    // Riders are held at their start while the field is being cleared
    rider #(
        .startX (startX1),
        .startY (startY)
    ) rider1 (
        .clk    (clk),
        .resetn (resetn),
        .tick   (tick),
        .hold   (roundOver),
        .keys   (steer1),
        .posX   (pos1X),
        .posY   (pos1Y)
    );

    rider #(
        .startX (startX2),
        .startY (startY)
    ) rider2 (
        .clk    (clk),
        .resetn (resetn),
        .tick   (tick),
        .hold   (roundOver),
        .keys   (steer2),
        .posX   (pos2X),
        .posY   (pos2Y)
    );

    arenaReferee referee (
        .clk        (clk),
        .resetn     (resetn),
        .tick       (tick),
        .pos1X      (pos1X),
        .pos1Y      (pos1Y),
        .pos2X      (pos2X),
        .pos2Y      (pos2Y),
        .plotX      (plotX),
        .plotY      (plotY),
        .plotColour (plotColour),
        .plotEn     (plotEn),
        .roundOver  (roundOver),
        .point1     (point1),
        .point2     (point2)
    );

    scoreBoard scores (
        .clk    (clk),
        .resetn (resetn),
        .point1 (point1),
        .point2 (point2),
        .score1 (score1),
        .score2 (score2)
    );

endmodule

// File: bench/tronArena_sva.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Referee assertions on plots, sweep and points
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module refereeAssertions (
    input logic                             clk,
    input logic                             resetn,
    input logic [arenaPkg::xWidth-1:0]      plotX,
    input logic [arenaPkg::yWidth-1:0]      plotY,
    input logic [arenaPkg::colourWidth-1:0] plotColour,
    input logic                             plotEn,
    input logic                             roundOver,
    input logic                             point1,
    input logic                             point2
);

    // A plot always carries a defined colour
    colourKnown: assert property (@(posedge clk) disable iff (!resetn)
        plotEn |-> !$isunknown(plotColour))
        else $error("plot with unknown colour");

    // Every plot during a round-over belongs to the sweep and stays inside
    sweepInside: assert property (@(posedge clk) disable iff (!resetn)
        (plotEn && roundOver) |-> (plotX >= arenaPkg::xFirst && plotX <= arenaPkg::xLast &&
                                   plotY >= arenaPkg::yFirst && plotY <= arenaPkg::yLast))
        else $error("sweep plot outside the interior");

    // A point only comes with the rise of round-over and never for both riders
    pointsApart: assert property (@(posedge clk) disable iff (!resetn)
        (point1 || point2) |-> (!(point1 && point2) && $rose(roundOver)))
        else $error("point pulse for both riders or away from a crash");

endmodule

bind arenaReferee refereeAssertions checks (.*);

// File: bench/tronArenaTb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Arena testbench with LFSR steering and a model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tronArenaTb;

    localparam int slowPeriod = 12;
    localparam int fastPeriod = 6;
    localparam int waitLimit  = 200;
    // Movement ticks allowed in one round before the run is given up
    localparam int stepLimit  = 5000;

    logic                                clk;
    logic                                resetn;
    logic                                fast;
    logic [steerPkg::steerWidth-1:0]     steer1;
    logic [steerPkg::steerWidth-1:0]     steer2;
    logic [arenaPkg::xWidth-1:0]         plotX;
    logic [arenaPkg::yWidth-1:0]         plotY;
    logic [arenaPkg::colourWidth-1:0]    plotColour;
    logic                                plotEn;
    logic                                roundOver;
    logic [7:0]                          score1;
    logic [7:0]                          score2;

    // Model state of both riders and the score board
    logic [arenaPkg::xWidth-1:0] x1;
    logic [arenaPkg::yWidth-1:0] y1;
    logic [arenaPkg::xWidth-1:0] x2;
    logic [arenaPkg::yWidth-1:0] y2;
    steerPkg::heading_t          h1;
    steerPkg::heading_t          h2;
    logic [7:0]                  modelScore1;
    logic [7:0]                  modelScore2;

    logic [15:0] lfsr;
    int          cycle;
    int          lastBlue;
    bit          gapValid;
    int          checks;
    int          errors;
    int          testErrors;
    int          rounds;
    int          roundSteps;
    bit          crashed;

    tronArena #(
        .slowPeriod (slowPeriod),
        .fastPeriod (fastPeriod)
    ) i_dut (
        .clk        (clk),
        .resetn     (resetn),
        .fast       (fast),
        .steer1     (steer1),
        .steer2     (steer2),
        .plotX      (plotX),
        .plotY      (plotY),
        .plotColour (plotColour),
        .plotEn     (plotEn),
        .roundOver  (roundOver),
        .score1     (score1),
        .score2     (score2)
    );

    always #4 clk = ~clk;

    // Free running cycle count for measuring the plot spacing
    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Fibonacci LFSR with taps 16, 14, 13 and 11 that steps once per bit
    function automatic logic [3:0] lfsrBits(input int n);
        logic [3:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            r = {r[2:0], lfsr[0]};
        end
        return r;
    endfunction

    // Mostly single keys with now and then no key or two keys at once
    function automatic logic [3:0] pickKeys();
        logic [3:0] sel;
        sel = lfsrBits(3);
        if (sel < 4) begin
            return 4'b0001 << sel;
        end else if (sel < 6) begin
            return 4'b0000;
        end else if (sel == 6) begin
            return 4'b0011;
        end
        return 4'b1100;
    endfunction

    // Only a single key at right angles to the travel direction turns
    function automatic steerPkg::heading_t turn(
        input steerPkg::heading_t h,
        input logic [3:0]         k
    );
        if (k == 4'b0001 && (h == steerPkg::headDown || h == steerPkg::headUp)) begin
            return steerPkg::headRight;
        end
        if (k == 4'b1000 && (h == steerPkg::headDown || h == steerPkg::headUp)) begin
            return steerPkg::headLeft;
        end
        if (k == 4'b0010 && (h == steerPkg::headLeft || h == steerPkg::headRight)) begin
            return steerPkg::headUp;
        end
        if (k == 4'b0100 && (h == steerPkg::headLeft || h == steerPkg::headRight)) begin
            return steerPkg::headDown;
        end
        return h;
    endfunction

    function automatic logic onWall(input logic [7:0] x, input logic [6:0] y);
        return x == 8'd10 || x == 8'd149 || y == 7'd17 || y == 7'd108;
    endfunction

    // Decimal increment that wraps 99 back to 00
    function automatic logic [7:0] bcdPlusOne(input logic [7:0] s);
        int v;
        v = (s[7:4] * 10 + s[3:0] + 1) % 100;
        return {4'(v / 10), 4'(v % 10)};
    endfunction

    task automatic checkCoord(
        input string                       name,
        input logic [arenaPkg::xWidth-1:0] gotX,
        input logic [arenaPkg::yWidth-1:0] gotY,
        input logic [arenaPkg::xWidth-1:0] expX,
        input logic [arenaPkg::yWidth-1:0] expY
    );
        checks++;
        if (gotX !== expX || gotY !== expY) begin
            errors++;
            $display("[ERROR] %s plotX=%h plotY=%h expected plotX=%h plotY=%h",
                     name, gotX, gotY, expX, expY);
        end
    endtask

    task automatic checkColour(
        input string                            name,
        input logic [arenaPkg::colourWidth-1:0] got,
        input logic [arenaPkg::colourWidth-1:0] exp
    );
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic checkScore(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic checkLevel(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic timeoutFail(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Some tests failed");
        $finish;
    endtask

    task automatic reportTest(input string name);
        $display("Test %s finished with %0d errors", name, errors - testErrors);
        testErrors = errors;
    endtask

    // Black plots over the interior with columns outside and rows inside
    task automatic watchSweep();
        int n;
        int i;
        n = 0;
        @(negedge clk);
        for (int x = 11; x <= 148; x++) begin
            for (int y = 18; y <= 107; y++) begin
                // The sweep clears one pixel in every cycle
                checkLevel("sweep plotEn", plotEn, 1'b1);
                checkCoord("sweep", plotX, plotY, 8'(x), 7'(y));
                checkColour("sweep plotColour", plotColour, arenaPkg::colourClear);
                if (plotEn) begin
                    n++;
                end
                @(negedge clk);
            end
        end
        // Plots that still come before roundOver falls are counted as extra
        for (i = 0; i < waitLimit && roundOver; i++) begin
            if (plotEn) begin
                n++;
            end
            @(negedge clk);
        end
        if (roundOver) begin
            timeoutFail("roundOver to fall");
        end
        checks++;
        if (n != 12420) begin
            errors++;
            $display("[ERROR] sweep plotEn count got %h expected %h", n, 12420);
        end
        checkScore("score1", score1, modelScore1);
        checkScore("score2", score2, modelScore2);
        x1 = arenaPkg::startX1;
        x2 = arenaPkg::startX2;
        y1 = arenaPkg::startY;
        y2 = arenaPkg::startY;
        h1 = steerPkg::headDown;
        h2 = steerPkg::headDown;
    endtask

    // One movement tick with keys and a speed toggle applied after the red plot
    task automatic runStep(input logic [3:0] k1, input logic [3:0] k2, input bit toggleFast);
        logic [7:0] nx1;
        logic [6:0] ny1;
        logic [7:0] nx2;
        logic [6:0] ny2;
        bit         c1;
        bit         c2;
        int         i;
        roundSteps++;
        if (roundSteps > stepLimit) begin
            timeoutFail("a crash to end the round");
        end
        nx1 = x1 + (h1 == steerPkg::headRight) - (h1 == steerPkg::headLeft);
        ny1 = y1 + (h1 == steerPkg::headDown) - (h1 == steerPkg::headUp);
        nx2 = x2 + (h2 == steerPkg::headRight) - (h2 == steerPkg::headLeft);
        ny2 = y2 + (h2 == steerPkg::headDown) - (h2 == steerPkg::headUp);
        c1 = onWall(nx1, ny1) || (nx1 == nx2 && ny1 == ny2);
        c2 = onWall(nx2, ny2) || (nx1 == nx2 && ny1 == ny2);
        for (i = 0; i < waitLimit && !plotEn && !roundOver; i++) begin
            @(negedge clk);
        end
        if (!plotEn && !roundOver) begin
            timeoutFail("a plot or the end of the round");
        end
        crashed = c1 || c2;
        if (crashed) begin
            checkLevel("plotEn", plotEn, 1'b0);
            checkLevel("roundOver", roundOver, 1'b1);
            if (c1 && !c2) begin
                modelScore2 = bcdPlusOne(modelScore2);
            end
            if (c2 && !c1) begin
                modelScore1 = bcdPlusOne(modelScore1);
            end
            gapValid = 0;
            roundSteps = 0;
            watchSweep();
        end else begin
            checkLevel("roundOver", roundOver, 1'b0);
            checkCoord("blue", plotX, plotY, nx1, ny1);
            checkColour("blue plotColour", plotColour, arenaPkg::colourRider1);
            if (gapValid && cycle - lastBlue != (fast ? fastPeriod : slowPeriod)) begin
                errors++;
                $display("[ERROR] blue plot gap got %h expected %h", cycle - lastBlue,
                         fast ? fastPeriod : slowPeriod);
            end
            lastBlue = cycle;
            gapValid = !toggleFast;
            @(negedge clk);
            checkLevel("plotEn", plotEn, 1'b1);
            checkCoord("red", plotX, plotY, nx2, ny2);
            checkColour("red plotColour", plotColour, arenaPkg::colourRider2);
            x1 = nx1;
            y1 = ny1;
            x2 = nx2;
            y2 = ny2;
            h1 = turn(h1, k1);
            h2 = turn(h2, k2);
            @(posedge clk);
            steer1 <= k1;
            steer2 <= k2;
            if (toggleFast) begin
                fast <= !fast;
            end
            @(posedge clk);
            steer1 <= '0;
            steer2 <= '0;
            @(negedge clk);
        end
    endtask

    initial begin
        clk         = 1'b0;
        resetn      = 1'b0;
        fast        = 1'b0;
        steer1      = '0;
        steer2      = '0;
        lfsr        = 16'd59;
        cycle       = 0;
        checks      = 0;
        errors      = 0;
        testErrors  = 0;
        gapValid    = 0;
        roundSteps  = 0;
        modelScore1 = 8'h00;
        modelScore2 = 8'h00;
        x1 = arenaPkg::startX1;
        x2 = arenaPkg::startX2;
        y1 = arenaPkg::startY;
        y2 = arenaPkg::startY;
        h1 = steerPkg::headDown;
        h2 = steerPkg::headDown;
        repeat (16) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        checkLevel("plotEn", plotEn, 1'b0);
        checkLevel("roundOver", roundOver, 1'b0);
        checkScore("score1", score1, 8'h00);
        checkScore("score2", score2, 8'h00);
        reportTest("reset");

        // Both riders run down into the bottom wall together so nobody scores
        crashed = 0;
        while (!crashed) begin
            runStep(4'b0000, 4'b0000, 1'b0);
        end
        reportTest("straight run, double wall crash and sweep");

        // Rider 1 turns right and rider 2 turns left until they meet in the middle
        runStep(4'b0001, 4'b1000, 1'b0);
        crashed = 0;
        while (!crashed) begin
            runStep(4'b0000, 4'b0000, 1'b0);
        end
        checkScore("score1 after head-on", score1, 8'h00);
        checkScore("score2 after head-on", score2, 8'h00);
        reportTest("head-on meeting");

        // Random rounds until one score carries into the tens digit
        rounds = 0;
        while (rounds < 60 && modelScore1 < 8'h11 && modelScore2 < 8'h11) begin
            runStep(pickKeys(), pickKeys(), lfsrBits(3) == 4'd7);
            if (crashed) begin
                rounds++;
            end
        end
        $display("Random rounds played %0d, scores %h and %h", rounds, score1, score2);
        reportTest("random steering, crashes and scores");

        @(posedge clk);
        fast <= 1'b1;
        gapValid = 0;
        rounds = 0;
        while (rounds < 3) begin
            runStep(pickKeys(), pickKeys(), 1'b0);
            if (crashed) begin
                rounds++;
            end
        end
        reportTest("fast period");

        $display("Checks run %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: src.f
logic/arenaPkg.sv
logic/steerPkg.sv
logic/moveTimer.sv
logic/riderSteer.sv
logic/rider.sv
logic/arenaReferee.sv
logic/scoreBoard.sv
logic/tronArena.sv
bench/tronArena_sva.sv
bench/tronArenaTb.sv

// File: run.sh
#!/bin/sh
# Build the arena testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tronArenaTb -f src.f \
    --Mdir obj_dir -o simTronArena
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simTronArena > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed" sim.log; then
    exit 0
fi
exit 1
